/* src/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// datapath and CSR address widths
`define CSR_XLEN 32
`define CSR_NUM_W 14
`define CSR_ECODE_W 6
`define CSR_ESUBCODE_W 9

// pending and enable vectors, IS12..IS0 / LIE12..LIE0
`define CSR_INT_W 13
`define CSR_ECFG_WMASK 13'h1bff     // bit 10 reserved

`define CSR_SAVE_N 4

// countdown parks here when it is not running
`define CSR_TIMER_IDLE 32'hffff_ffff

`define CSR_CRMD_RESET 9'h008       // da=1, everything else clear
`define CSR_REG_RESET 32'h0000_0000

`define CSR_EENTRY_ALIGN 6          // low bits of eentry are zero
`define CSR_PC_STEP 32'd4

`define CSR_ASSERT_ON 1'b1

`endif

/* src/csr_pkg.sv */
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

  typedef enum logic [`CSR_NUM_W-1:0] {
    CSR_CRMD   = 14'h000,
    CSR_PRMD   = 14'h001,
    CSR_ECFG   = 14'h004,
    CSR_ESTAT  = 14'h005,
    CSR_ERA    = 14'h006,
    CSR_BADV   = 14'h007,
    CSR_EENTRY = 14'h00c,
    CSR_SAVE0  = 14'h030,
    CSR_SAVE1  = 14'h031,
    CSR_SAVE2  = 14'h032,
    CSR_SAVE3  = 14'h033,
    CSR_TID    = 14'h040,
    CSR_TCFG   = 14'h041,
    CSR_TVAL   = 14'h042,
    CSR_TICLR  = 14'h044
  } csr_num_e;

  typedef enum logic [`CSR_ECODE_W-1:0] {
    ECODE_INT = 6'h00,
    ECODE_ADE = 6'h08,  // address error, updates badv
    ECODE_ALE = 6'h09,  // misaligned access, updates badv
    ECODE_SYS = 6'h0b,
    ECODE_BRK = 6'h0c,
    ECODE_INE = 6'h0d
  } ecode_e;

  typedef struct packed {
    logic                 we;
    csr_num_e             num;
    logic [`CSR_XLEN-1:0] wvalue;
    logic [`CSR_XLEN-1:0] wmask;
  } csr_wr_t;

  typedef struct packed {
    logic                       ex;
    logic                       ertn;
    ecode_e                     ecode;
    logic [`CSR_ESUBCODE_W-1:0] esubcode;
    logic [`CSR_XLEN-1:0]       pc;
    logic [`CSR_XLEN-1:0]       badv;
    logic                       exc_if;  // fault raised at fetch
  } exc_req_t;

  // field order follows the architectural bit layout, msb first
  typedef struct packed {
    logic [1:0] datm;
    logic [1:0] datf;
    logic       pg;
    logic       da;
    logic       ie;
    logic [1:0] plv;
  } crmd_t;

  typedef struct packed {
    logic       pie;
    logic [1:0] pplv;
  } prmd_t;

  typedef struct packed {
    logic [`CSR_XLEN-3:0] initval;
    logic                 periodic;
    logic                 en;
  } tcfg_t;

  typedef struct packed {
    logic                 valid;
    logic [`CSR_XLEN-1:0] target;
  } redirect_t;

  function automatic logic [`CSR_XLEN-1:0] mask_merge(
    input logic [`CSR_XLEN-1:0] old_val,
    input logic [`CSR_XLEN-1:0] wvalue,
    input logic [`CSR_XLEN-1:0] wmask
  );
    return (wvalue & wmask) | (old_val & ~wmask);
  endfunction

endpackage

`default_nettype wire

/* src/csr_exc_state.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_exc_state (
  input  logic                             clk,
  input  logic                             reset,
  input  csr_pkg::csr_wr_t                 csr_wr,
  input  csr_pkg::exc_req_t                exc_req,
  input  logic [`CSR_XLEN-1:0]             wb_pc,
  output csr_pkg::crmd_t                   crmd,
  output csr_pkg::prmd_t                   prmd,
  output csr_pkg::ecode_e                  ecode,
  output logic [`CSR_ESUBCODE_W-1:0]       esubcode,
  output logic [`CSR_XLEN-1:0]             era,
  output logic [`CSR_XLEN-1:0]             eentry,
  output logic [`CSR_XLEN-1:0]             badv,
  output csr_pkg::redirect_t               redirect
);

  logic                 wr_ok;
  logic                 addr_fault;
  logic [`CSR_XLEN-1:0] crmd_merged;
  logic [`CSR_XLEN-1:0] prmd_merged;
  logic [`CSR_XLEN-1:0] era_merged;
  logic [`CSR_XLEN-1:0] eentry_merged;

  // exception wins over ertn, ertn over a csr write
  assign wr_ok = csr_wr.we && !exc_req.ex && !exc_req.ertn;

  assign addr_fault = (exc_req.ecode == csr_pkg::ECODE_ADE) ||
                      (exc_req.ecode == csr_pkg::ECODE_ALE);

  assign crmd_merged   = csr_pkg::mask_merge(`CSR_XLEN'(crmd), csr_wr.wvalue, csr_wr.wmask);
  assign prmd_merged   = csr_pkg::mask_merge(`CSR_XLEN'(prmd), csr_wr.wvalue, csr_wr.wmask);
  assign era_merged    = csr_pkg::mask_merge(era, csr_wr.wvalue, csr_wr.wmask);
  assign eentry_merged = csr_pkg::mask_merge(eentry, csr_wr.wvalue, csr_wr.wmask);

  always_ff @(posedge clk) begin
    if (reset) begin
      crmd <= csr_pkg::crmd_t'(`CSR_CRMD_RESET);
    end else if (exc_req.ex) begin
      crmd.plv <= 2'b00;  // enter kernel with ints off
      crmd.ie  <= 1'b0;
    end else if (exc_req.ertn) begin
      crmd.plv <= prmd.pplv;
      crmd.ie  <= prmd.pie;
    end else if (wr_ok && csr_wr.num == csr_pkg::CSR_CRMD) begin
      crmd <= crmd_merged[$bits(csr_pkg::crmd_t)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prmd <= '0;
    end else if (exc_req.ex) begin
      prmd.pplv <= crmd.plv;
      prmd.pie  <= crmd.ie;
    end else if (wr_ok && csr_wr.num == csr_pkg::CSR_PRMD) begin
      prmd <= prmd_merged[$bits(csr_pkg::prmd_t)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ecode    <= csr_pkg::ECODE_INT;
      esubcode <= '0;
      era      <= `CSR_REG_RESET;
      badv     <= `CSR_REG_RESET;
    end else if (exc_req.ex) begin
      ecode    <= exc_req.ecode;
      esubcode <= exc_req.esubcode;
      era      <= exc_req.pc;
      if (addr_fault) begin
        badv <= exc_req.exc_if ? exc_req.pc : exc_req.badv;
      end
    end else if (wr_ok && csr_wr.num == csr_pkg::CSR_ERA) begin
      era <= era_merged;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      eentry <= `CSR_REG_RESET;
    end else if (wr_ok && csr_wr.num == csr_pkg::CSR_EENTRY) begin
      eentry <= {eentry_merged[`CSR_XLEN-1:`CSR_EENTRY_ALIGN], {`CSR_EENTRY_ALIGN{1'b0}}};
    end
  end

  assign redirect.valid  = exc_req.ex || exc_req.ertn;
  assign redirect.target = exc_req.ex   ? eentry :
                           exc_req.ertn ? era :
                           wb_pc + `CSR_PC_STEP;

  if (`CSR_ASSERT_ON) begin : g_assert
    // write-back retires one flush cause at a time
    a_ex_ertn_onehot: assert property (
      @(posedge clk) disable iff (reset) !(exc_req.ex && exc_req.ertn)
    );
  end

endmodule

`default_nettype wire

/* src/csr_timer.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_wr_t     csr_wr,
  output logic [`CSR_XLEN-1:0] tid,
  output csr_pkg::tcfg_t       tcfg,
  output logic [`CSR_XLEN-1:0] tval,
  output logic                 timer_expire
);

  logic                 wr_tid;
  logic                 wr_tcfg;
  logic [`CSR_XLEN-1:0] tcfg_next;
  logic [`CSR_XLEN-1:0] count;

  assign wr_tid  = csr_wr.we && csr_wr.num == csr_pkg::CSR_TID;
  assign wr_tcfg = csr_wr.we && csr_wr.num == csr_pkg::CSR_TCFG;

  // config as it will look after this write
  assign tcfg_next = csr_pkg::mask_merge(tcfg, csr_wr.wvalue, csr_wr.wmask);

  always_ff @(posedge clk) begin
    if (reset) begin
      tid <= `CSR_REG_RESET;
    end else if (wr_tid) begin
      tid <= csr_pkg::mask_merge(tid, csr_wr.wvalue, csr_wr.wmask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tcfg <= '0;
    end else if (wr_tcfg) begin
      tcfg <= csr_pkg::tcfg_t'(tcfg_next);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= `CSR_TIMER_IDLE;
    end else if (wr_tcfg && tcfg_next[0]) begin
      count <= {tcfg_next[`CSR_XLEN-1:2], 2'b00};  // initval is in units of 4
    end else if (tcfg.en && count != `CSR_TIMER_IDLE) begin
      if (count == '0 && tcfg.periodic) begin
        count <= {tcfg.initval, 2'b00};
      end else begin
        count <= count - `CSR_XLEN'(1);  // one-shot wraps to idle
      end
    end
  end

  assign tval         = count;
  assign timer_expire = (count == '0);

  if (`CSR_ASSERT_ON) begin : g_assert
    // a one-shot count that hits zero parks at idle
    a_oneshot_idle: assert property (
      @(posedge clk) disable iff (reset)
      (tcfg.en && !tcfg.periodic && count == '0 && !wr_tcfg) |=>
        (count == `CSR_TIMER_IDLE)
    );
  end

endmodule

`default_nettype wire

/* src/csr_int_ctrl.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_int_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  csr_pkg::csr_wr_t      csr_wr,
  input  logic                  timer_expire,
  input  logic                  ie,
  output logic [`CSR_INT_W-1:0] ecfg_lie,
  output logic [`CSR_INT_W-1:0] estat_is,
  output logic                  has_int
);

  logic [`CSR_INT_W-1:0] lie_mask;
  logic [1:0]            is_sw;
  logic                  is_timer;

  // reserved lie bit never takes a write
  assign lie_mask = csr_wr.wmask[`CSR_INT_W-1:0] & `CSR_ECFG_WMASK;

  always_ff @(posedge clk) begin
    if (reset) begin
      ecfg_lie <= '0;
    end else if (csr_wr.we && csr_wr.num == csr_pkg::CSR_ECFG) begin
      ecfg_lie <= (csr_wr.wvalue[`CSR_INT_W-1:0] & lie_mask) | (ecfg_lie & ~lie_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_sw <= 2'b00;
    end else if (csr_wr.we && csr_wr.num == csr_pkg::CSR_ESTAT) begin
      is_sw <= (csr_wr.wvalue[1:0] & csr_wr.wmask[1:0]) | (is_sw & ~csr_wr.wmask[1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_timer <= 1'b0;
    end else if (timer_expire) begin
      is_timer <= 1'b1;  // expiry beats a same-cycle clear
    end else if (csr_wr.we && csr_wr.num == csr_pkg::CSR_TICLR &&
                 csr_wr.wvalue[0] && csr_wr.wmask[0]) begin
      is_timer <= 1'b0;
    end
  end

  // ipi and hw lines are not wired in
  assign estat_is = {1'b0, is_timer, 1'b0, 8'b0, is_sw};

  assign has_int = ((estat_is & ecfg_lie) != '0) && ie;

endmodule

`default_nettype wire

/* src/csr_save_bank.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_save_bank (
  input  logic                                   clk,
  input  logic                                   reset,
  input  csr_pkg::csr_wr_t                       csr_wr,
  output logic [`CSR_SAVE_N-1:0][`CSR_XLEN-1:0]  save
);

  for (genvar i = 0; i < `CSR_SAVE_N; i++) begin : g_save
    localparam logic [`CSR_NUM_W-1:0] SEL_NUM =
      `CSR_NUM_W'(csr_pkg::CSR_SAVE0) + `CSR_NUM_W'(i);

    logic [`CSR_XLEN-1:0] q;

    always_ff @(posedge clk) begin
      if (reset) begin
        q <= `CSR_REG_RESET;
      end else if (csr_wr.we && csr_wr.num == SEL_NUM) begin
        q <= csr_pkg::mask_merge(q, csr_wr.wvalue, csr_wr.wmask);
      end
    end

    assign save[i] = q;
  end

endmodule

`default_nettype wire

/* src/csr_rd_mux.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_rd_mux (
  input  csr_pkg::csr_num_e                      num,
  input  csr_pkg::crmd_t                         crmd,
  input  csr_pkg::prmd_t                         prmd,
  input  logic [`CSR_INT_W-1:0]                  ecfg_lie,
  input  logic [`CSR_INT_W-1:0]                  estat_is,
  input  csr_pkg::ecode_e                        ecode,
  input  logic [`CSR_ESUBCODE_W-1:0]             esubcode,
  input  logic [`CSR_XLEN-1:0]                   era,
  input  logic [`CSR_XLEN-1:0]                   eentry,
  input  logic [`CSR_XLEN-1:0]                   badv,
  input  logic [`CSR_SAVE_N-1:0][`CSR_XLEN-1:0]  save,
  input  logic [`CSR_XLEN-1:0]                   tid,
  input  csr_pkg::tcfg_t                         tcfg,
  input  logic [`CSR_XLEN-1:0]                   tval,
  output logic [`CSR_XLEN-1:0]                   rd_value
);

  logic [`CSR_XLEN-1:0] estat_word;

  // esubcode 30:22, ecode 21:16, is 12:0
  assign estat_word = `CSR_XLEN'({esubcode, ecode, 3'b000, estat_is});

  always_comb begin
    case (num)
      csr_pkg::CSR_CRMD:   rd_value = `CSR_XLEN'(crmd);
      csr_pkg::CSR_PRMD:   rd_value = `CSR_XLEN'(prmd);
      csr_pkg::CSR_ECFG:   rd_value = `CSR_XLEN'(ecfg_lie);
      csr_pkg::CSR_ESTAT:  rd_value = estat_word;
      csr_pkg::CSR_ERA:    rd_value = era;
      csr_pkg::CSR_BADV:   rd_value = badv;
      csr_pkg::CSR_EENTRY: rd_value = eentry;
      csr_pkg::CSR_SAVE0:  rd_value = save[0];
      csr_pkg::CSR_SAVE1:  rd_value = save[1];
      csr_pkg::CSR_SAVE2:  rd_value = save[2];
      csr_pkg::CSR_SAVE3:  rd_value = save[3];
      csr_pkg::CSR_TID:    rd_value = tid;
      csr_pkg::CSR_TCFG:   rd_value = tcfg;
      csr_pkg::CSR_TVAL:   rd_value = tval;
      default:             rd_value = '0;  // ticlr is write-only
    endcase
  end

endmodule

`default_nettype wire

/* src/csr_top.sv */
`default_nettype none

`include "csr_cfg.svh"

module csr_top (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_wr_t     csr_wr,
  input  csr_pkg::exc_req_t    exc_req,
  input  logic [`CSR_XLEN-1:0] wb_pc,
  output logic [`CSR_XLEN-1:0] rd_value,
  output csr_pkg::redirect_t   redirect,
  output logic [1:0]           plv,
  output logic                 has_int
);

  csr_pkg::crmd_t                        crmd;
  csr_pkg::prmd_t                        prmd;
  csr_pkg::ecode_e                       ecode;
  logic [`CSR_ESUBCODE_W-1:0]            esubcode;
  logic [`CSR_XLEN-1:0]                  era;
  logic [`CSR_XLEN-1:0]                  eentry;
  logic [`CSR_XLEN-1:0]                  badv;
  logic [`CSR_XLEN-1:0]                  tid;
  csr_pkg::tcfg_t                        tcfg;
  logic [`CSR_XLEN-1:0]                  tval;
  logic                                  timer_expire;
  logic [`CSR_INT_W-1:0]                 ecfg_lie;
  logic [`CSR_INT_W-1:0]                 estat_is;
  logic [`CSR_SAVE_N-1:0][`CSR_XLEN-1:0] save;

  csr_exc_state u_exc_state (
    .clk      (clk),
    .reset    (reset),
    .csr_wr   (csr_wr),
    .exc_req  (exc_req),
    .wb_pc    (wb_pc),
    .crmd     (crmd),
    .prmd     (prmd),
    .ecode    (ecode),
    .esubcode (esubcode),
    .era      (era),
    .eentry   (eentry),
    .badv     (badv),
    .redirect (redirect)
  );

  csr_timer u_timer (
    .clk          (clk),
    .reset        (reset),
    .csr_wr       (csr_wr),
    .tid          (tid),
    .tcfg         (tcfg),
    .tval         (tval),
    .timer_expire (timer_expire)
  );

  csr_int_ctrl u_int_ctrl (
    .clk          (clk),
    .reset        (reset),
    .csr_wr       (csr_wr),
    .timer_expire (timer_expire),
    .ie           (crmd.ie),
    .ecfg_lie     (ecfg_lie),
    .estat_is     (estat_is),
    .has_int      (has_int)
  );

  csr_save_bank u_save_bank (
    .clk    (clk),
    .reset  (reset),
    .csr_wr (csr_wr),
    .save   (save)
  );

  csr_rd_mux u_rd_mux (
    .num      (csr_wr.num),
    .crmd     (crmd),
    .prmd     (prmd),
    .ecfg_lie (ecfg_lie),
    .estat_is (estat_is),
    .ecode    (ecode),
    .esubcode (esubcode),
    .era      (era),
    .eentry   (eentry),
    .badv     (badv),
    .save     (save),
    .tid      (tid),
    .tcfg     (tcfg),
    .tval     (tval),
    .rd_value (rd_value)
  );

  assign plv = crmd.plv;

endmodule

`default_nettype wire

/* dv/tb_csr_table.svh */
// rows are built here; each helper call is one cycle of stimulus with its expected outputs
// read value is for the row's csr number and shows state from before that row's edge

task automatic build_table();
  logic [`CSR_NUM_W-1:0] rw_nums [0:6];
  lcg_state = 32'h97c186af;
  next_pc   = 32'h1c00_0000;
  cur_plv   = 2'd0;
  rw_nums[0] = csr_pkg::CSR_SAVE0;
  rw_nums[1] = csr_pkg::CSR_SAVE1;
  rw_nums[2] = csr_pkg::CSR_SAVE2;
  rw_nums[3] = csr_pkg::CSR_SAVE3;
  rw_nums[4] = csr_pkg::CSR_ERA;
  rw_nums[5] = csr_pkg::CSR_TID;
  rw_nums[6] = csr_pkg::CSR_EENTRY;

  // random masked writes then read back
  foreach (rw_nums[k]) begin
    rand_write(rw_nums[k]);
    rand_write(rw_nums[k]);
    expect_read(rw_nums[k], shadow[rw_nums[k]], 1'b0);
  end

  // exception entry from plv 3 with ie set
  csr_write(csr_pkg::CSR_EENTRY, 32'h1c00_8000, 32'hffff_ffff, shadow[csr_pkg::CSR_EENTRY], 1'b0);
  csr_write(csr_pkg::CSR_CRMD, 32'h0000_0007, 32'h0000_0007, 32'h0000_0008, 1'b0);
  cur_plv = 2'd3;
  take_exception(csr_pkg::CSR_CRMD, 32'h0000_000f, 6'h0b, 9'h000, 1'b0,
                 32'h1c00_0100, 32'hdead_beef, 32'h1c00_8000, 1'b0);
  cur_plv = 2'd0;  // kernel after entry
  expect_read(csr_pkg::CSR_CRMD, 32'h0000_0008, 1'b0);
  expect_read(csr_pkg::CSR_PRMD, 32'h0000_0007, 1'b0);
  expect_read(csr_pkg::CSR_ERA, 32'h1c00_0100, 1'b0);
  expect_read(csr_pkg::CSR_ESTAT, 32'h000b_0000, 1'b0);
  expect_read(csr_pkg::CSR_BADV, 32'h0000_0000, 1'b0);

  // badv sources: ale from badv, fetch ade from pc, sys untouched
  take_exception(csr_pkg::CSR_BADV, 32'h0000_0000, 6'h09, 9'h000, 1'b0,
                 32'h1c00_0200, 32'h0000_1233, 32'h1c00_8000, 1'b0);
  expect_read(csr_pkg::CSR_BADV, 32'h0000_1233, 1'b0);
  take_exception(csr_pkg::CSR_ESTAT, 32'h0009_0000, 6'h08, 9'h001, 1'b1,
                 32'h1c00_0302, 32'h5555_5555, 32'h1c00_8000, 1'b0);
  expect_read(csr_pkg::CSR_BADV, 32'h1c00_0302, 1'b0);
  expect_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, 1'b0);
  take_exception(csr_pkg::CSR_BADV, 32'h1c00_0302, 6'h0b, 9'h000, 1'b0,
                 32'h1c00_0400, 32'h7777_0000, 32'h1c00_8000, 1'b0);
  expect_read(csr_pkg::CSR_BADV, 32'h1c00_0302, 1'b0);

  // ertn back to plv 3 with ie set
  csr_write(csr_pkg::CSR_PRMD, 32'h0000_0007, 32'h0000_0007, 32'h0000_0000, 1'b0);
  exc_return(csr_pkg::CSR_CRMD, 32'h0000_0008, 32'h1c00_0400, 1'b0);
  cur_plv = 2'd3;  // restored from pplv
  expect_read(csr_pkg::CSR_CRMD, 32'h0000_000f, 1'b0);

  // one-shot timer, initval 4
  csr_write(csr_pkg::CSR_ECFG, 32'h0000_0800, 32'h0000_1fff, 32'h0000_0000, 1'b0);
  csr_write(csr_pkg::CSR_TCFG, 32'h0000_0011, 32'hffff_ffff, 32'h0000_0000, 1'b0);
  for (int n = 16; n >= 0; n--) begin
    expect_read(csr_pkg::CSR_TVAL, 32'(n), 1'b0);
  end
  expect_read(csr_pkg::CSR_ESTAT, 32'h000b_0800, 1'b1);
  expect_read(csr_pkg::CSR_TVAL, 32'hffff_ffff, 1'b1);
  csr_write(csr_pkg::CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 1'b1);
  expect_read(csr_pkg::CSR_ESTAT, 32'h000b_0000, 1'b0);

  // periodic timer, initval 2
  csr_write(csr_pkg::CSR_TCFG, 32'h0000_000b, 32'hffff_ffff, 32'h0000_0011, 1'b0);
  for (int n = 8; n >= 0; n--) begin
    expect_read(csr_pkg::CSR_TVAL, 32'(n), 1'b0);
  end
  expect_read(csr_pkg::CSR_TVAL, 32'h0000_0008, 1'b1);  // reloaded
  expect_read(csr_pkg::CSR_TVAL, 32'h0000_0007, 1'b1);
  csr_write(csr_pkg::CSR_TCFG, 32'h0000_0000, 32'h0000_0001, 32'h0000_000b, 1'b1);
  csr_write(csr_pkg::CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 1'b1);

  // write-only and unmapped numbers
  expect_read(csr_pkg::CSR_TICLR, 32'h0000_0000, 1'b0);
  expect_read(14'h010, 32'h0000_0000, 1'b0);
endtask

/* dv/tb_csr.sv */
`default_nettype none

`include "csr_cfg.svh"

module tb_csr;

  typedef enum logic [1:0] {
    OP_IDLE,
    OP_WR,
    OP_EX,
    OP_ERTN
  } op_e;

  // one cycle of stimulus plus what the outputs must show during it
  typedef struct packed {
    op_e                        op;
    logic [`CSR_NUM_W-1:0]      num;
    logic [`CSR_XLEN-1:0]       value;
    logic [`CSR_XLEN-1:0]       mask;
    logic [`CSR_XLEN-1:0]       pc;
    logic [`CSR_XLEN-1:0]       badv;
    logic [`CSR_ECODE_W-1:0]    ecode;
    logic [`CSR_ESUBCODE_W-1:0] esub;
    logic                       exc_if;
    logic [`CSR_XLEN-1:0]       exp_rd;
    logic                       exp_valid;
    logic [`CSR_XLEN-1:0]       exp_tgt;
    logic                       exp_int;
    logic [1:0]                 exp_plv;
  } row_t;

  logic                 clk;
  logic                 reset;
  csr_pkg::csr_wr_t     csr_wr;
  csr_pkg::exc_req_t    exc_req;
  logic [`CSR_XLEN-1:0] wb_pc;
  logic [`CSR_XLEN-1:0] rd_value;
  csr_pkg::redirect_t   redirect;
  logic [1:0]           plv;
  logic                 has_int;

  row_t                 table_q[$];
  bit [`CSR_XLEN-1:0]   shadow [0:(1 << `CSR_NUM_W)-1];  // expected masked-write contents
  logic [31:0]          lcg_state;
  logic [`CSR_XLEN-1:0] next_pc;
  logic [1:0]           cur_plv;  // privilege level while the next row runs
  logic                 table_ready = 1'b0;
  int                   rd_errs;
  int                   redir_errs;
  int                   int_errs;
  int                   plv_errs;

  csr_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .csr_wr   (csr_wr),
    .exc_req  (exc_req),
    .wb_pc    (wb_pc),
    .rd_value (rd_value),
    .redirect (redirect),
    .plv      (plv),
    .has_int  (has_int)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sequential fetch pc, no redirect expected unless overridden
  function automatic row_t blank_row(input op_e op, input logic [`CSR_NUM_W-1:0] num,
                                     input logic [`CSR_XLEN-1:0] exp_rd, input logic exp_int);
    row_t r;
    r           = '0;
    r.op        = op;
    r.num       = num;
    r.pc        = next_pc;
    r.exp_rd    = exp_rd;
    r.exp_valid = (op == OP_EX) || (op == OP_ERTN);
    r.exp_tgt   = next_pc + 32'd4;
    r.exp_int   = exp_int;
    r.exp_plv   = cur_plv;
    next_pc     = next_pc + 32'd4;
    return r;
  endfunction

  task automatic csr_write(input logic [`CSR_NUM_W-1:0] num, input logic [`CSR_XLEN-1:0] value,
                           input logic [`CSR_XLEN-1:0] mask, input logic [`CSR_XLEN-1:0] exp_rd,
                           input logic exp_int);
    row_t r;
    r       = blank_row(OP_WR, num, exp_rd, exp_int);
    r.value = value;
    r.mask  = mask;
    table_q.push_back(r);
    shadow[num] = (value & mask) | (shadow[num] & ~mask);
    if (num == csr_pkg::CSR_EENTRY) begin
      shadow[num][5:0] = 6'b0;  // entry is 64-byte aligned
    end
  endtask

  task automatic rand_write(input logic [`CSR_NUM_W-1:0] num);
    logic [`CSR_XLEN-1:0] v;
    logic [`CSR_XLEN-1:0] m;
    v = lcg_next();
    m = lcg_next();
    csr_write(num, v, m, shadow[num], 1'b0);
  endtask

  task automatic expect_read(input logic [`CSR_NUM_W-1:0] num,
                             input logic [`CSR_XLEN-1:0] exp_rd, input logic exp_int);
    table_q.push_back(blank_row(OP_IDLE, num, exp_rd, exp_int));
  endtask

  task automatic take_exception(input logic [`CSR_NUM_W-1:0] num,
                                input logic [`CSR_XLEN-1:0] exp_rd,
                                input logic [`CSR_ECODE_W-1:0] ecode,
                                input logic [`CSR_ESUBCODE_W-1:0] esub, input logic exc_if,
                                input logic [`CSR_XLEN-1:0] pc, input logic [`CSR_XLEN-1:0] badv,
                                input logic [`CSR_XLEN-1:0] entry, input logic exp_int);
    row_t r;
    r         = blank_row(OP_EX, num, exp_rd, exp_int);
    r.ecode   = ecode;
    r.esub    = esub;
    r.exc_if  = exc_if;
    r.pc      = pc;
    r.badv    = badv;
    r.exp_tgt = entry;
    table_q.push_back(r);
  endtask

  task automatic exc_return(input logic [`CSR_NUM_W-1:0] num, input logic [`CSR_XLEN-1:0] exp_rd,
                            input logic [`CSR_XLEN-1:0] era, input logic exp_int);
    row_t r;
    r         = blank_row(OP_ERTN, num, exp_rd, exp_int);
    r.exp_tgt = era;
    table_q.push_back(r);
  endtask

  `include "tb_csr_table.svh"

  task automatic apply_row(input row_t r);
    csr_wr.we        = (r.op == OP_WR);
    csr_wr.num       = csr_pkg::csr_num_e'(r.num);
    csr_wr.wvalue    = r.value;
    csr_wr.wmask     = r.mask;
    exc_req.ex       = (r.op == OP_EX);
    exc_req.ertn     = (r.op == OP_ERTN);
    exc_req.ecode    = csr_pkg::ecode_e'(r.ecode);
    exc_req.esubcode = r.esub;
    exc_req.pc       = r.pc;
    exc_req.badv     = r.badv;
    exc_req.exc_if   = r.exc_if;
    wb_pc            = r.pc;
  endtask

  task automatic check_row(input int idx, input row_t r);
    assert (rd_value === r.exp_rd) else begin
      rd_errs++;
      $display("error: rd_value row %0d num %h got %h expected %h",
               idx, r.num, rd_value, r.exp_rd);
    end
    assert (redirect.valid === r.exp_valid) else begin
      redir_errs++;
      $display("error: redirect.valid row %0d got %h expected %h",
               idx, redirect.valid, r.exp_valid);
    end
    assert (redirect.target === r.exp_tgt) else begin
      redir_errs++;
      $display("error: redirect.target row %0d got %h expected %h",
               idx, redirect.target, r.exp_tgt);
    end
    assert (has_int === r.exp_int) else begin
      int_errs++;
      $display("error: has_int row %0d got %h expected %h", idx, has_int, r.exp_int);
    end
    assert (plv === r.exp_plv) else begin
      plv_errs++;
      $display("error: plv row %0d got %h expected %h", idx, plv, r.exp_plv);
    end
  endtask

  initial begin : main
    int total;
    clk        = 1'b0;
    reset      = 1'b1;
    csr_wr     = '0;
    exc_req    = '0;
    wb_pc      = '0;
    rd_errs    = 0;
    redir_errs = 0;
    int_errs   = 0;
    plv_errs   = 0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
      #70;  // outputs settled, next edge not yet
      check_row(i, table_q[i]);
      @(posedge clk);
      #10;
    end
    total = rd_errs + redir_errs + int_errs + plv_errs;
    $display({"rows %0d, rd_value errors %0d, redirect errors %0d, has_int errors %0d, ",
              "plv errors %0d"},
             table_q.size(), rd_errs, redir_errs, int_errs, plv_errs);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    longint unsigned limit;
    wait (table_ready);
    limit = (longint'(table_q.size()) + 200) * 100;
    #(limit);
    $display("timeout: table did not complete within %0d time units", limit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
+incdir+dv
src/csr_pkg.sv
src/csr_exc_state.sv
src/csr_timer.sv
src/csr_int_ctrl.sv
src/csr_save_bank.sv
src/csr_rd_mux.sv
src/csr_top.sv
dv/tb_csr.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_csr
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh dv/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
